// ==== include/adc_acq_defs.svh ====
`ifndef ADC_ACQ_DEFS_SVH
`define ADC_ACQ_DEFS_SVH

////////////////////////////////
// field widths
////////////////////////////////
`define ADC_SAMPLE_W     12   // one adc sample
`define BURST_CNT_W      23   // bursts per waveform
`define WFM_CNT_W        12   // waveforms per fill
`define GAP_CNT_W        22   // idle cycles between waveforms
`define FILL_NUM_W       24   // fill number
`define CHAN_TAG_W       12   // channel info carried in headers
`define ACQ_PAYLOAD_W    128  // header or data payload
`define ACQ_TAG_W        4    // word type tag above the payload
`define PAIRS_PER_BURST  4    // sample pairs collected per data word

////////////////////////////////
// channel_tag bit positions
////////////////////////////////
`define CHAN_TAG_DUMMY_BIT       3  // 1 -> dummy counter replaces real samples
`define CHAN_TAG_RESET_MODE_BIT  4  // 1 -> dummy counter cleared every waveform

`endif

// ==== src/adc_acq_pkg.sv ====
`include "adc_acq_defs.svh"

package adc_acq_pkg;

    ////////////////////////////////
    // enums
    ////////////////////////////////
    typedef enum logic [1:0] {
        FILL_NONE  = 2'd0,  // not enabled, triggers ignored
        FILL_MUON  = 2'd1,
        FILL_LASER = 2'd2,
        FILL_PED   = 2'd3
    } fill_type_e;  // value is {acq_enable1, acq_enable0}

    typedef enum logic [2:0] {
        ACQ_IDLE, ACQ_FILL_HDR, ACQ_WFM_HDR, ACQ_DATA, ACQ_GAP, ACQ_DONE
    } acq_state_e;

    typedef enum logic [`ACQ_TAG_W-1:0] {
        TAG_NONE     = 4'd0,
        TAG_FILL_HDR = 4'd1,
        TAG_WFM_HDR  = 4'd2,
        TAG_DATA     = 4'd3
    } frame_tag_e;

    ////////////////////////////////
    // packed structs
    ////////////////////////////////
    typedef struct packed {
        logic [`ADC_SAMPLE_W-1:0] second_smp;  // later sample of the pair
        logic                     second_ovr;
        logic [`ADC_SAMPLE_W-1:0] first_smp;
        logic                     first_ovr;   // bit 0
    } sample_pair_t;

    typedef struct packed {
        logic [`BURST_CNT_W-1:0] num_bursts;
        logic [`WFM_CNT_W-1:0]   num_waveforms;
        logic [`GAP_CNT_W-1:0]   waveform_gap;
    } fill_cfg_t;

    typedef struct packed {
        logic [32:0]              zero;  // pad to 128
        logic [`FILL_NUM_W-1:0]   fill_num;
        fill_type_e               fill_type;
        logic [`CHAN_TAG_W-1:0]   channel_tag;
        logic [`BURST_CNT_W-1:0]  num_bursts;
        logic [`WFM_CNT_W-1:0]    num_waveforms;
        logic [`GAP_CNT_W-1:0]    waveform_gap;
    } fill_hdr_t;

    typedef struct packed {
        logic [56:0]              zero;  // pad to 128
        logic [`FILL_NUM_W-1:0]   fill_num;
        logic [`WFM_CNT_W-1:0]    waveform_num;
        logic [`CHAN_TAG_W-1:0]   channel_tag;
        logic [`BURST_CNT_W-1:0]  num_bursts;
    } wfm_hdr_t;

    typedef struct packed {
        sample_pair_t [`PAIRS_PER_BURST-1:0] pair;  // pair[0] is the oldest
    } burst_t;

    typedef struct packed {
        frame_tag_e                tag;
        logic [`ACQ_PAYLOAD_W-1:0] payload;
    } acq_word_t;

endpackage

// ==== src/adc_fill_config.sv ====
module adc_fill_config (
    input  logic                    adc_clk,
    input  logic                    dummy_dat_reset,
    input  logic                    acq_enable0,
    input  logic                    acq_enable1,
    input  logic                    trig_accept,  // fill starts at this edge
    input  adc_acq_pkg::fill_cfg_t  muon_cfg,
    input  adc_acq_pkg::fill_cfg_t  laser_cfg,
    input  adc_acq_pkg::fill_cfg_t  ped_cfg,
    output adc_acq_pkg::fill_type_e cur_type,
    output adc_acq_pkg::fill_cfg_t  cur_cfg,
    output logic                    acq_enabled
);

    adc_acq_pkg::fill_cfg_t sel_cfg;  // settings for the type selected right now

    assign cur_type    = adc_acq_pkg::fill_type_e'({acq_enable1, acq_enable0});
    assign acq_enabled = acq_enable0 | acq_enable1;  // acquisition mode, not readout

    always_comb begin
        case (cur_type)
            adc_acq_pkg::FILL_MUON:  sel_cfg = muon_cfg;
            adc_acq_pkg::FILL_LASER: sel_cfg = laser_cfg;
            adc_acq_pkg::FILL_PED:   sel_cfg = ped_cfg;
            default:                 sel_cfg = '0;  // no fill type, never latched
        endcase
    end

    // hold the settings for the whole fill so the counters see stable limits
    always_ff @(posedge adc_clk) begin
        if (dummy_dat_reset) begin
            cur_cfg <= '0;
        end else if (trig_accept) begin
            cur_cfg <= sel_cfg;  // latched only when a trigger is taken
        end
    end

endmodule

// ==== src/adc_acq_cntrs.sv ====
`include "adc_acq_defs.svh"

module adc_acq_cntrs (
    input  logic                   adc_clk,
    input  logic                   dummy_dat_reset,
    input  adc_acq_pkg::fill_cfg_t cur_cfg,
    input  logic                   wfm_start,     // waveform header cycle
    input  logic                   burst_done,    // one burst sent
    input  logic                   wfm_done,      // last burst of the waveform sent
    input  logic                   fill_done,     // fill finished
    input  logic                   trig_accept,   // new fill starting
    input  logic [`FILL_NUM_W-1:0] initial_fill_num,
    input  logic                   initial_fill_num_wr,
    output logic                   burst_zero,
    output logic                   last_wfm,
    output logic                   gap_zero,
    output logic [`WFM_CNT_W-1:0]  waveform_num,
    output logic [`FILL_NUM_W-1:0] fill_num
);

    logic [`BURST_CNT_W-1:0] burst_cnt;  // bursts still to send in this waveform
    logic [`GAP_CNT_W-1:0]   gap_cnt;    // idle cycles left before the next waveform

    ////////////////////////////////
    // burst down-counter
    ////////////////////////////////
    always_ff @(posedge adc_clk) begin
        if (dummy_dat_reset) begin
            burst_cnt <= '0;
        end else if (wfm_start) begin
            burst_cnt <= cur_cfg.num_bursts;     // reload every waveform
        end else if (burst_done && !burst_zero) begin
            burst_cnt <= burst_cnt - 1'b1;
        end
    end

    assign burst_zero = (burst_cnt == '0);

    ////////////////////////////////
    // waveform up-counter
    ////////////////////////////////
    always_ff @(posedge adc_clk) begin
        if (dummy_dat_reset || trig_accept) begin
            waveform_num <= '0;                  // first waveform of a fill is 0
        end else if (wfm_done) begin
            waveform_num <= waveform_num + 1'b1;
        end
    end

    assign last_wfm = (waveform_num == cur_cfg.num_waveforms - 1'b1);

    ////////////////////////////////
    // gap down-counter
    ////////////////////////////////
    always_ff @(posedge adc_clk) begin
        if (dummy_dat_reset) begin
            gap_cnt <= '0;
        end else if (wfm_done) begin
            gap_cnt <= cur_cfg.waveform_gap;     // starts with the gap state
        end else if (!gap_zero) begin
            gap_cnt <= gap_cnt - 1'b1;
        end
    end

    assign gap_zero = (gap_cnt == '0);

    // fill number, programmed once per run and bumped after each fill
    always_ff @(posedge adc_clk) begin
        if (dummy_dat_reset) begin
            fill_num <= '0;
        end else if (initial_fill_num_wr) begin
            fill_num <= initial_fill_num;
        end else if (fill_done) begin
            fill_num <= fill_num + 1'b1;
        end
    end

endmodule

// ==== src/adc_acq_sm.sv ====
`include "adc_acq_defs.svh"

module adc_acq_sm (
    input  logic                    adc_clk,
    input  logic                    dummy_dat_reset,
    input  logic                    acq_trig,
    input  adc_acq_pkg::fill_type_e cur_type,     // FILL_NONE means not enabled
    input  logic                    burst_zero,
    input  logic                    last_wfm,
    input  logic                    gap_zero,
    output logic                    trig_accept,
    output logic                    wfm_start,
    output logic                    burst_done,
    output logic                    wfm_done,
    output logic                    fill_done,
    output adc_acq_pkg::acq_state_e state,
    output logic                    sm_idle,
    output logic                    acq_done
);

    localparam int PHASE_W = $clog2(`PAIRS_PER_BURST);

    adc_acq_pkg::acq_state_e state_next;
    logic [PHASE_W-1:0]      phase;  // position of the current pair inside a burst

    ////////////////////////////////
    // strobes decoded from state
    ////////////////////////////////
    assign trig_accept = (state == adc_acq_pkg::ACQ_IDLE) && acq_trig &&
                         (cur_type != adc_acq_pkg::FILL_NONE);  // enable check lives here
    assign wfm_start   = (state == adc_acq_pkg::ACQ_WFM_HDR);
    assign burst_done  = (state == adc_acq_pkg::ACQ_DATA) &&
                         (phase == PHASE_W'(`PAIRS_PER_BURST - 1));  // every 4th data cycle
    assign wfm_done    = (state == adc_acq_pkg::ACQ_DATA) && burst_zero;
    assign fill_done   = (state == adc_acq_pkg::ACQ_DONE);
    assign acq_done    = (state == adc_acq_pkg::ACQ_DONE);  // single cycle state
    assign sm_idle     = (state == adc_acq_pkg::ACQ_IDLE);

    // burst phase, always starts from 0 since data follows a header cycle
    always_ff @(posedge adc_clk) begin
        if (dummy_dat_reset || state != adc_acq_pkg::ACQ_DATA) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;  // wraps after the last pair
        end
    end

    ////////////////////////////////
    // next state
    ////////////////////////////////
    always_comb begin
        state_next = state;
        case (state)
            adc_acq_pkg::ACQ_IDLE: begin
                if (trig_accept) begin
                    state_next = adc_acq_pkg::ACQ_FILL_HDR;  // late triggers never get here
                end
            end
            adc_acq_pkg::ACQ_FILL_HDR: state_next = adc_acq_pkg::ACQ_WFM_HDR;  // 1 cycle
            adc_acq_pkg::ACQ_WFM_HDR:  state_next = adc_acq_pkg::ACQ_DATA;     // 1 cycle
            adc_acq_pkg::ACQ_DATA: begin
                if (burst_zero) begin  // all bursts of this waveform are out
                    state_next = last_wfm ? adc_acq_pkg::ACQ_DONE : adc_acq_pkg::ACQ_GAP;
                end
            end
            adc_acq_pkg::ACQ_GAP: begin
                if (gap_zero) begin
                    state_next = adc_acq_pkg::ACQ_WFM_HDR;  // next waveform
                end
            end
            adc_acq_pkg::ACQ_DONE: state_next = adc_acq_pkg::ACQ_IDLE;
            default:               state_next = adc_acq_pkg::ACQ_IDLE;
        endcase
    end

    always_ff @(posedge adc_clk) begin
        if (dummy_dat_reset) begin
            state <= adc_acq_pkg::ACQ_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

// ==== src/adc_sample_pipe.sv ====
`include "adc_acq_defs.svh"

module adc_sample_pipe (
    input  logic                      adc_clk,
    input  logic                      dummy_dat_reset,
    input  adc_acq_pkg::sample_pair_t adc_sample,   // packed pair, every cycle
    input  logic [`CHAN_TAG_W-1:0]    channel_tag,
    input  logic                      wfm_start,
    output adc_acq_pkg::burst_t       burst
);

    logic [`ADC_SAMPLE_W-1:0]  dummy_cnt;
    logic [`ADC_SAMPLE_W-1:0]  dummy_val;  // counter value offered this cycle
    logic                      wfm_clear;
    adc_acq_pkg::sample_pair_t new_pair;

    // in reset mode the waveform header cycle already offers 0, so the first
    // burst of each waveform holds 0,1,2,3
    assign wfm_clear = wfm_start && channel_tag[`CHAN_TAG_RESET_MODE_BIT];
    assign dummy_val = wfm_clear ? '0 : dummy_cnt;

    always_ff @(posedge adc_clk) begin
        if (dummy_dat_reset) begin
            dummy_cnt <= '0;
        end else begin
            dummy_cnt <= dummy_val + 1'b1;  // free-runs between clears
        end
    end

    ////////////////////////////////
    // real / dummy select
    ////////////////////////////////
    always_comb begin
        if (channel_tag[`CHAN_TAG_DUMMY_BIT]) begin
            new_pair.second_smp = ~dummy_val;  // inverted counter
            new_pair.second_ovr = 1'b0;
            new_pair.first_smp  = dummy_val;   // normal counter
            new_pair.first_ovr  = 1'b0;
        end else begin
            new_pair = adc_sample;
        end
    end

    // pair[3] is the input register, older pairs shift down toward pair[0]
    always_ff @(posedge adc_clk) begin
        burst.pair <= {new_pair, burst.pair[`PAIRS_PER_BURST-1:1]};
    end

endmodule

// ==== src/adc_frame_mux.sv ====
`include "adc_acq_defs.svh"

module adc_frame_mux (
    input  logic                    adc_clk,
    input  logic                    dummy_dat_reset,
    input  adc_acq_pkg::acq_state_e state,
    input  logic                    burst_done,
    input  adc_acq_pkg::burst_t     burst,
    input  adc_acq_pkg::fill_cfg_t  cur_cfg,
    input  adc_acq_pkg::fill_type_e cur_type,
    input  logic [`CHAN_TAG_W-1:0]  channel_tag,
    input  logic [`WFM_CNT_W-1:0]   waveform_num,
    input  logic [`FILL_NUM_W-1:0]  fill_num,
    output adc_acq_pkg::acq_word_t  acq_out,
    output logic                    acq_out_valid
);

    adc_acq_pkg::fill_hdr_t fill_hdr;
    adc_acq_pkg::wfm_hdr_t  wfm_hdr;
    adc_acq_pkg::acq_word_t word;  // word for the next edge
    logic                   word_valid;

    always_comb begin
        fill_hdr               = '0;
        fill_hdr.fill_num      = fill_num;
        fill_hdr.fill_type     = cur_type;
        fill_hdr.channel_tag   = channel_tag;
        fill_hdr.num_bursts    = cur_cfg.num_bursts;
        fill_hdr.num_waveforms = cur_cfg.num_waveforms;
        fill_hdr.waveform_gap  = cur_cfg.waveform_gap;

        wfm_hdr              = '0;
        wfm_hdr.fill_num     = fill_num;
        wfm_hdr.waveform_num = waveform_num;
        wfm_hdr.channel_tag  = channel_tag;
        wfm_hdr.num_bursts   = cur_cfg.num_bursts;
    end

    ////////////////////////////////
    // word select
    ////////////////////////////////
    always_comb begin
        word.tag     = adc_acq_pkg::TAG_NONE;
        word.payload = `ACQ_PAYLOAD_W'(burst);  // data, 24 zero bits on top
        word_valid   = 1'b0;
        if (state == adc_acq_pkg::ACQ_FILL_HDR) begin
            word.tag     = adc_acq_pkg::TAG_FILL_HDR;
            word.payload = fill_hdr;
            word_valid   = 1'b1;
        end else if (state == adc_acq_pkg::ACQ_WFM_HDR) begin
            word.tag     = adc_acq_pkg::TAG_WFM_HDR;
            word.payload = wfm_hdr;
            word_valid   = 1'b1;
        end else if (burst_done) begin
            word.tag   = adc_acq_pkg::TAG_DATA;  // burst complete this cycle
            word_valid = 1'b1;
        end
    end

    always_ff @(posedge adc_clk) begin
        if (dummy_dat_reset) begin
            acq_out.tag   <= adc_acq_pkg::TAG_NONE;
            acq_out_valid <= 1'b0;
        end else begin
            acq_out.tag   <= word.tag;
            acq_out_valid <= word_valid;  // one cycle per word, no back-pressure
        end
        acq_out.payload <= word.payload;
    end

endmodule

// ==== src/adc_acq_top.sv ====
`include "adc_acq_defs.svh"

module adc_acq_top (
    input  logic                      adc_clk,
    input  logic                      dummy_dat_reset,
    input  adc_acq_pkg::sample_pair_t adc_sample,
    input  logic [`CHAN_TAG_W-1:0]    channel_tag,
    input  adc_acq_pkg::fill_cfg_t    muon_cfg,
    input  adc_acq_pkg::fill_cfg_t    laser_cfg,
    input  adc_acq_pkg::fill_cfg_t    ped_cfg,
    input  logic [`FILL_NUM_W-1:0]    initial_fill_num,
    input  logic                      initial_fill_num_wr,  // already on adc_clk
    input  logic                      acq_enable0,
    input  logic                      acq_enable1,
    input  logic                      acq_trig,
    output logic                      acq_enabled,
    output logic [`FILL_NUM_W-1:0]    fill_num,
    output adc_acq_pkg::acq_word_t    acq_out,
    output logic                      acq_out_valid,
    output logic                      acq_done,
    output logic                      sm_idle
);

    adc_acq_pkg::fill_cfg_t  cur_cfg;
    adc_acq_pkg::fill_type_e cur_type;
    adc_acq_pkg::acq_state_e state;
    adc_acq_pkg::burst_t     burst;
    logic                    trig_accept, wfm_start, burst_done, wfm_done, fill_done;
    logic                    burst_zero, last_wfm, gap_zero;
    logic [`WFM_CNT_W-1:0]   waveform_num;

    ////////////////////////////////
    // configuration
    ////////////////////////////////
    adc_fill_config u_fill_config (
        .adc_clk(adc_clk), .dummy_dat_reset(dummy_dat_reset),
        .acq_enable0(acq_enable0), .acq_enable1(acq_enable1),
        .trig_accept(trig_accept),
        .muon_cfg(muon_cfg), .laser_cfg(laser_cfg), .ped_cfg(ped_cfg),
        .cur_type(cur_type), .cur_cfg(cur_cfg), .acq_enabled(acq_enabled)
    );

    // counters and sequencer
    adc_acq_cntrs u_cntrs (
        .adc_clk(adc_clk), .dummy_dat_reset(dummy_dat_reset), .cur_cfg(cur_cfg),
        .wfm_start(wfm_start), .burst_done(burst_done), .wfm_done(wfm_done),
        .fill_done(fill_done), .trig_accept(trig_accept),
        .initial_fill_num(initial_fill_num), .initial_fill_num_wr(initial_fill_num_wr),
        .burst_zero(burst_zero), .last_wfm(last_wfm), .gap_zero(gap_zero),
        .waveform_num(waveform_num), .fill_num(fill_num)
    );

    adc_acq_sm u_sm (
        .adc_clk(adc_clk), .dummy_dat_reset(dummy_dat_reset), .acq_trig(acq_trig),
        .cur_type(cur_type), .burst_zero(burst_zero), .last_wfm(last_wfm),
        .gap_zero(gap_zero), .trig_accept(trig_accept), .wfm_start(wfm_start),
        .burst_done(burst_done), .wfm_done(wfm_done), .fill_done(fill_done),
        .state(state), .sm_idle(sm_idle), .acq_done(acq_done)
    );

    ////////////////////////////////
    // sample chain and formatter
    ////////////////////////////////
    adc_sample_pipe u_sample_pipe (
        .adc_clk(adc_clk), .dummy_dat_reset(dummy_dat_reset), .adc_sample(adc_sample),
        .channel_tag(channel_tag), .wfm_start(wfm_start), .burst(burst)
    );

    adc_frame_mux u_frame_mux (
        .adc_clk(adc_clk), .dummy_dat_reset(dummy_dat_reset), .state(state),
        .burst_done(burst_done), .burst(burst), .cur_cfg(cur_cfg), .cur_type(cur_type),
        .channel_tag(channel_tag), .waveform_num(waveform_num), .fill_num(fill_num),
        .acq_out(acq_out), .acq_out_valid(acq_out_valid)
    );

endmodule

// ==== sim/adc_acq_tb.sv ====
`include "adc_acq_defs.svh"

module adc_acq_tb;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_ROWS   = 5;
    localparam int BURST_BITS = $bits(adc_acq_pkg::burst_t);  // data sits below the zero pad

    typedef struct packed {
        logic                   en1, en0;     // {en1,en0} is the fill type
        adc_acq_pkg::fill_cfg_t muon, laser, ped;
        logic [`CHAN_TAG_W-1:0] chan_tag;
        logic                   wr_fill;      // program initial_fill_num first
        logic [`FILL_NUM_W-1:0] init_fill;
        logic                   expect_fill;  // trigger should start a fill
        logic                   mid_trig;     // second trigger while busy
    } test_row_t;

    logic                      adc_clk, dummy_dat_reset;
    adc_acq_pkg::sample_pair_t adc_sample;
    logic [`CHAN_TAG_W-1:0]    channel_tag;
    adc_acq_pkg::fill_cfg_t    muon_cfg, laser_cfg, ped_cfg;
    logic [`FILL_NUM_W-1:0]    initial_fill_num, fill_num;
    logic                      initial_fill_num_wr, acq_enable0, acq_enable1, acq_trig;
    logic                      acq_enabled, acq_out_valid, acq_done, sm_idle;
    adc_acq_pkg::acq_word_t    acq_out;

    test_row_t                 rows [NUM_ROWS];
    logic                      table_loaded = 1'b0;
    adc_acq_pkg::acq_word_t    words [$];           // every valid word, arrival order
    int                        done_count = 0;      // acq_done pulses seen
    int                        fills_expected = 0;
    logic [`FILL_NUM_W-1:0]    exp_fill;            // number the next fill must carry
    integer                    seed = 32'h780a68c8;
    logic [31:0]               ramp_base, ramp_step;

    adc_acq_top u_dut (.*);

    initial begin
        adc_clk = 1'b0;
        forever #(CLK_PERIOD / 2) adc_clk = ~adc_clk;
    end

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////
    // ramp step n: first = base + 2n, second = first + 1, over-range bits alternate
    function automatic adc_acq_pkg::sample_pair_t ramp_pair(input logic [31:0] base,
                                                            input logic [31:0] step);
        adc_acq_pkg::sample_pair_t p;
        p.first_smp  = base[`ADC_SAMPLE_W-1:0] + {step[`ADC_SAMPLE_W-2:0], 1'b0};
        p.second_smp = p.first_smp + 1'b1;
        p.first_ovr  = step[0];
        p.second_ovr = ~step[0];
        return p;
    endfunction

    function automatic adc_acq_pkg::fill_cfg_t make_cfg(input int bursts, input int wfms,
                                                        input int gap);
        adc_acq_pkg::fill_cfg_t cfg;
        cfg.num_bursts    = `BURST_CNT_W'(bursts);
        cfg.num_waveforms = `WFM_CNT_W'(wfms);
        cfg.waveform_gap  = `GAP_CNT_W'(gap);
        return cfg;
    endfunction

    function automatic adc_acq_pkg::fill_cfg_t select_cfg(input test_row_t row);
        case ({row.en1, row.en0})
            2'b01:   return row.muon;
            2'b10:   return row.laser;
            2'b11:   return row.ped;
            default: return '0;  // not enabled
        endcase
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERROR at time %0t: %s expected 0x%0h actual 0x%0h",
                     $time, name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // adc_sample walks the ramp, one step per falling edge
    initial begin
        ramp_base  = $random(seed);
        ramp_step  = '0;
        adc_sample = ramp_pair(ramp_base, ramp_step);
        forever begin
            @(negedge adc_clk);
            ramp_step  = ramp_step + 1;
            adc_sample = ramp_pair(ramp_base, ramp_step);
        end
    end

    always @(negedge adc_clk) begin  // mid-cycle, outputs are settled
        if (acq_out_valid) words.push_back(acq_out);
        if (acq_done) done_count = done_count + 1;
    end

    // budget per row: waveforms x (bursts x 4 + gap + 4) plus 20 idle cycles, doubled
    initial begin
        longint limit;
        adc_acq_pkg::fill_cfg_t cfg;
        wait (table_loaded);
        limit = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            cfg   = select_cfg(rows[r]);
            limit = limit + 20 + longint'(cfg.num_waveforms) *
                    (longint'(cfg.num_bursts) * 4 + longint'(cfg.waveform_gap) + 4);
        end
        limit = 2 * limit + 20;
        #(limit * CLK_PERIOD);
        $display("ERROR at time %0t: watchdog ran out after %0d cycles, a fill never completed",
                 $time, limit);
        $display("** FAIL **");
        $fatal(1, "simulation timed out");
    end

    //////////////////////////////
    // word checks for one fill
    //////////////////////////////
    task automatic check_fill_words(input test_row_t row, input int first_idx);
        adc_acq_pkg::fill_cfg_t    cfg;
        adc_acq_pkg::fill_hdr_t    fh;
        adc_acq_pkg::wfm_hdr_t     wh;
        adc_acq_pkg::burst_t       bst;
        adc_acq_pkg::sample_pair_t pj;
        logic [`ADC_SAMPLE_W-1:0]  exp_first, exp_second, start, prev_start, prev_wfm_start;
        logic [`ADC_SAMPLE_W-1:0]  step;
        logic [`WFM_CNT_W-1:0]     wfm_idx;
        logic                      dummy, exp_ovr, exp_ovr2, advanced;
        int                        nb, nw, idx;
        cfg   = select_cfg(row);
        nb    = int'(cfg.num_bursts);
        nw    = int'(cfg.num_waveforms);
        dummy = row.chan_tag[`CHAN_TAG_DUMMY_BIT];
        check_value("word count", 64'(1 + nw * (nb + 1)), 64'(words.size() - first_idx));
        fh = words[first_idx].payload;
        check_value("fill_hdr tag", 64'(adc_acq_pkg::TAG_FILL_HDR), 64'(words[first_idx].tag));
        check_value("fill_hdr.zero", 64'(0), 64'(fh.zero));
        check_value("fill_hdr.fill_num", 64'(exp_fill), 64'(fh.fill_num));
        check_value("fill_hdr.fill_type", 64'({row.en1, row.en0}), 64'(fh.fill_type));
        check_value("fill_hdr.channel_tag", 64'(row.chan_tag), 64'(fh.channel_tag));
        check_value("fill_hdr.num_bursts", 64'(cfg.num_bursts), 64'(fh.num_bursts));
        check_value("fill_hdr.num_waveforms", 64'(cfg.num_waveforms), 64'(fh.num_waveforms));
        check_value("fill_hdr.waveform_gap", 64'(cfg.waveform_gap), 64'(fh.waveform_gap));
        idx = first_idx + 1;
        for (int wi = 0; wi < nw; wi++) begin
            wh      = words[idx].payload;
            wfm_idx = `WFM_CNT_W'(wi);
            check_value("wfm_hdr tag", 64'(adc_acq_pkg::TAG_WFM_HDR), 64'(words[idx].tag));
            check_value("wfm_hdr.zero", 64'(0), 64'(wh.zero));
            check_value("wfm_hdr.fill_num", 64'(exp_fill), 64'(wh.fill_num));
            check_value("wfm_hdr.waveform_num", 64'(wfm_idx), 64'(wh.waveform_num));
            check_value("wfm_hdr.channel_tag", 64'(row.chan_tag), 64'(wh.channel_tag));
            check_value("wfm_hdr.num_bursts", 64'(cfg.num_bursts), 64'(wh.num_bursts));
            idx++;
            for (int b = 0; b < nb; b++) begin
                check_value("data tag", 64'(adc_acq_pkg::TAG_DATA), 64'(words[idx].tag));
                check_value("data pad", 64'(0),
                            64'(words[idx].payload[`ACQ_PAYLOAD_W-1:BURST_BITS]));
                bst   = words[idx].payload[BURST_BITS-1:0];
                start = bst.pair[0].first_smp;  // oldest pair opens the word
                for (int j = 0; j < `PAIRS_PER_BURST; j++) begin
                    pj = bst.pair[j];
                    if (dummy) begin
                        exp_first  = start + `ADC_SAMPLE_W'(j);  // counter, +1 per pair
                        exp_second = ~exp_first;
                        exp_ovr    = 1'b0;
                        exp_ovr2   = 1'b0;
                    end else begin
                        exp_first  = start + `ADC_SAMPLE_W'(2 * j);  // one ramp step per pair
                        exp_second = exp_first + 1'b1;
                        exp_ovr    = bst.pair[0].first_ovr ^ j[0];
                        exp_ovr2   = ~exp_ovr;
                    end
                    check_value("pair.first_smp", 64'(exp_first), 64'(pj.first_smp));
                    check_value("pair.second_smp", 64'(exp_second), 64'(pj.second_smp));
                    check_value("pair.first_ovr", 64'(exp_ovr), 64'(pj.first_ovr));
                    check_value("pair.second_ovr", 64'(exp_ovr2), 64'(pj.second_ovr));
                end
                if (b > 0) begin
                    step      = dummy ? `ADC_SAMPLE_W'(4) : `ADC_SAMPLE_W'(8);  // four pairs on
                    exp_first = prev_start + step;
                    check_value("data word start", 64'(exp_first), 64'(start));
                end else if (wi > 0 && dummy) begin
                    if (row.chan_tag[`CHAN_TAG_RESET_MODE_BIT]) begin
                        check_value("reset-mode waveform start", 64'(prev_wfm_start), 64'(start));
                    end else begin
                        step     = start - prev_wfm_start;
                        advanced = (int'(step) > 4 * nb);  // at least one waveform of cycles
                        check_value("free-run waveform start advanced", 64'(1), 64'(advanced));
                    end
                end
                if (b == 0) prev_wfm_start = start;
                prev_start = start;
                idx++;
            end
        end
    endtask

    task automatic run_row(input int r);
        test_row_t              row;
        int                     first_idx, start_done;
        logic [`FILL_NUM_W-1:0] next_fill;
        row = rows[r];
        @(negedge adc_clk);
        acq_enable0 = row.en0;
        acq_enable1 = row.en1;
        muon_cfg    = row.muon;
        laser_cfg   = row.laser;
        ped_cfg     = row.ped;
        channel_tag = row.chan_tag;
        if (row.wr_fill) begin
            initial_fill_num    = row.init_fill;
            initial_fill_num_wr = 1'b1;
            exp_fill            = row.init_fill;
        end
        @(negedge adc_clk);
        initial_fill_num_wr = 1'b0;
        check_value("acq_enabled", 64'(row.en0 | row.en1), 64'(acq_enabled));
        check_value("sm_idle", 64'(1), 64'(sm_idle));
        check_value("fill_num", 64'(exp_fill), 64'(fill_num));
        first_idx  = words.size();
        start_done = done_count;
        acq_trig   = 1'b1;  // one rising edge with the trigger high
        @(negedge adc_clk);
        acq_trig = 1'b0;
        if (row.expect_fill) begin
            if (row.mid_trig) begin
                repeat (3) @(negedge adc_clk);
                check_value("sm_idle", 64'(0), 64'(sm_idle));
                acq_trig = 1'b1;  // must be ignored, fill in progress
                @(negedge adc_clk);
                acq_trig = 1'b0;
            end
            while (done_count == start_done) @(negedge adc_clk);
            @(negedge adc_clk);  // fill_num steps at the edge closing the done cycle
            next_fill = exp_fill + 1'b1;
            check_value("fill_num", 64'(next_fill), 64'(fill_num));
            repeat (6) @(negedge adc_clk);
            check_value("acq_done pulses", 64'(start_done + 1), 64'(done_count));
            check_fill_words(row, first_idx);
            exp_fill = next_fill;
            fills_expected++;
        end else begin
            repeat (10) @(negedge adc_clk);
            check_value("word count", 64'(first_idx), 64'(words.size()));
            check_value("acq_done pulses", 64'(start_done), 64'(done_count));
        end
        check_value("sm_idle", 64'(1), 64'(sm_idle));
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin
        dummy_dat_reset     = 1'b1;
        channel_tag         = '0;
        muon_cfg            = '0;
        laser_cfg           = '0;
        ped_cfg             = '0;
        initial_fill_num    = '0;
        initial_fill_num_wr = 1'b0;
        acq_enable0         = 1'b0;
        acq_enable1         = 1'b0;
        acq_trig            = 1'b0;
        exp_fill            = '0;  // fill counter clears on reset
        // muon reset-mode dummy, laser free-run dummy, ped real, disabled, muon real
        rows[0] = '{en1: 1'b0, en0: 1'b1, muon: make_cfg(3, 3, 5), laser: make_cfg(2, 2, 0),
                    ped: make_cfg(4, 2, 3), chan_tag: 12'h518, wr_fill: 1'b1,
                    init_fill: 24'h001234, expect_fill: 1'b1, mid_trig: 1'b0};
        rows[1] = '{en1: 1'b1, en0: 1'b0, muon: make_cfg(1, 1, 1), laser: make_cfg(2, 3, 0),
                    ped: make_cfg(5, 1, 2), chan_tag: 12'h608, wr_fill: 1'b0,
                    init_fill: 24'h0, expect_fill: 1'b1, mid_trig: 1'b1};
        rows[2] = '{en1: 1'b1, en0: 1'b1, muon: make_cfg(2, 2, 2), laser: make_cfg(1, 4, 1),
                    ped: make_cfg(4, 2, 3), chan_tag: 12'h0a0, wr_fill: 1'b0,
                    init_fill: 24'h0, expect_fill: 1'b1, mid_trig: 1'b0};
        rows[3] = '{en1: 1'b0, en0: 1'b0, muon: make_cfg(2, 2, 2), laser: make_cfg(2, 2, 2),
                    ped: make_cfg(2, 2, 2), chan_tag: 12'h008, wr_fill: 1'b0,
                    init_fill: 24'h0, expect_fill: 1'b0, mid_trig: 1'b0};
        rows[4] = '{en1: 1'b0, en0: 1'b1, muon: make_cfg(2, 2, 1), laser: make_cfg(3, 1, 0),
                    ped: make_cfg(1, 3, 4), chan_tag: 12'h0c7, wr_fill: 1'b1,
                    init_fill: 24'hffffff, expect_fill: 1'b1, mid_trig: 1'b0};
        table_loaded = 1'b1;
        repeat (4) @(posedge adc_clk);
        @(negedge adc_clk);
        dummy_dat_reset = 1'b0;
        @(negedge adc_clk);
        check_value("acq_out_valid", 64'(0), 64'(acq_out_valid));
        check_value("acq_done", 64'(0), 64'(acq_done));
        check_value("sm_idle", 64'(1), 64'(sm_idle));
        check_value("acq_out.tag", 64'(adc_acq_pkg::TAG_NONE), 64'(acq_out.tag));
        check_value("acq_enabled", 64'(0), 64'(acq_enabled));
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        check_value("total acq_done pulses", 64'(fills_expected), 64'(done_count));
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== adc_acq_top.f ====
+incdir+include
src/adc_acq_pkg.sv
src/adc_fill_config.sv
src/adc_acq_cntrs.sv
src/adc_acq_sm.sv
src/adc_sample_pipe.sv
src/adc_frame_mux.sv
src/adc_acq_top.sv
sim/adc_acq_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build adc_acq_tb with verilator, run it, then look for the pass line in sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f adc_acq_top.f --top-module adc_acq_tb -o adc_acq_sim \
    && ./obj_dir/adc_acq_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -qxF '** PASS **' sim.log \
    && echo "result: passed" \
    || { echo "result: failed"; exit 1; }
